// File: dot_defines.svh
`ifndef DOT_DEFINES_SVH
`define DOT_DEFINES_SVH

// lanes per vector beat
`define DOT_LANES 4

// input samples, signed Q1.7
`define DOT_SAMPLE_W 8
`define DOT_SAMPLE_FRAC 7

// lane products, signed Q2.10
`define DOT_PROD_W 12
`define DOT_PROD_FRAC 10

// fraction bits dropped from the raw 16-bit product
`define DOT_PROD_SHIFT (2 * `DOT_SAMPLE_FRAC - `DOT_PROD_FRAC)

// two tree levels, one bit of growth each
`define DOT_SUM_W (`DOT_PROD_W + 2)

`endif

// File: dot_pkg.sv
`include "dot_defines.svh"

package dot_pkg;

    // one signed Q1.7 sample
    typedef logic signed [`DOT_SAMPLE_W-1:0] sample_t;

    // lane 0 in the low bits
    typedef logic [`DOT_LANES*`DOT_SAMPLE_W-1:0] sample_vec_t;

    // one signed Q2.10 lane product
    typedef logic signed [`DOT_PROD_W-1:0] product_t;

    // all lane products, same packing as the samples
    typedef logic [`DOT_LANES*`DOT_PROD_W-1:0] product_vec_t;

    // full precision dot product, Q4.10
    typedef logic signed [`DOT_SUM_W-1:0] sum_t;

endpackage

// File: stream_if.sv
`timescale 1ns/1ps

interface stream_if #(
    parameter type data_t = logic
) ();
    data_t data;
    logic  last;
    logic  valid;
    logic  ready;

    // producer side of the link
    modport source (
        output data,
        output last,
        output valid,
        input  ready
    );

    // consumer side of the link
    modport sink (
        input  data,
        input  last,
        input  valid,
        output ready
    );
endinterface

// File: lane_mul_stage.sv
`timescale 1ns/1ps
`include "dot_defines.svh"

module lane_mul_stage import dot_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  sample_vec_t a_data,
    input  logic        a_last,
    input  logic        a_valid,
    output logic        a_ready,
    input  sample_vec_t b_data,
    input  logic        b_valid,
    output logic        b_ready,
    stream_if.source    out
);
    logic         stage_ready;
    logic         join_fire;
    product_vec_t prod_next;

    // register is free when empty or draining this cycle
    assign stage_ready = ~out.valid | out.ready;

    // each side waits on the other's valid, never on its own
    assign a_ready   = b_valid & stage_ready;
    assign b_ready   = a_valid & stage_ready;
    assign join_fire = a_valid & b_valid & stage_ready;

    for (genvar i = 0; i < `DOT_LANES; i++) begin : g_lane
        sample_t                           a_s;
        sample_t                           b_s;
        logic signed [2*`DOT_SAMPLE_W-1:0] raw;
        logic signed [2*`DOT_SAMPLE_W-1:0] scaled;
        product_t                          prod;

        assign a_s = a_data[i*`DOT_SAMPLE_W +: `DOT_SAMPLE_W];
        assign b_s = b_data[i*`DOT_SAMPLE_W +: `DOT_SAMPLE_W];
        assign raw = (2*`DOT_SAMPLE_W)'(a_s) * (2*`DOT_SAMPLE_W)'(b_s);

        // Q2.14 down to Q2.10, dropped top bits are only sign
        assign scaled = raw >>> `DOT_PROD_SHIFT;
        assign prod   = scaled[`DOT_PROD_W-1:0];

        assign prod_next[i*`DOT_PROD_W +: `DOT_PROD_W] = prod;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out.valid <= 1'b0;
        end else if (join_fire) begin
            out.valid <= 1'b1;
        end else if (out.ready) begin
            out.valid <= 1'b0;
        end
    end

    // last comes from A only, B carries no framing
    always_ff @(posedge clk) begin
        if (join_fire) begin
            out.data <= prod_next;
            out.last <= a_last;
        end
    end

    a_hold_stable: assert property (@(posedge clk) disable iff (rst)
        out.valid && !out.ready |=> $stable(out.data) && $stable(out.last));

endmodule

// File: tree_level.sv
`timescale 1ns/1ps

module tree_level #(
    parameter int in_count = 4,
    parameter int in_width = 12
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [in_count*in_width-1:0]         in_data,
    input  logic                                 in_last,
    input  logic                                 in_valid,
    output logic                                 in_ready,
    output logic [(in_count/2)*(in_width+1)-1:0] out_data,
    output logic                                 out_last,
    output logic                                 out_valid,
    input  logic                                 out_ready
);
    localparam int out_count = in_count / 2;
    localparam int out_width = in_width + 1;

    logic                           in_fire;
    logic [out_count*out_width-1:0] sum_next;

    if (in_count % 2 != 0) begin : g_check
        $error("tree_level needs an even operand count");
    end

    // one handshake for every adder in the level
    assign in_ready = ~out_valid | out_ready;
    assign in_fire  = in_valid & in_ready;

    for (genvar i = 0; i < out_count; i++) begin : g_pair
        logic [in_width-1:0] op_a;
        logic [in_width-1:0] op_b;

        assign op_a = in_data[(2*i)*in_width +: in_width];
        assign op_b = in_data[(2*i+1)*in_width +: in_width];

        // sign extend by one bit so the pair sum cannot overflow
        assign sum_next[i*out_width +: out_width] =
            {op_a[in_width-1], op_a} + {op_b[in_width-1], op_b};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_fire) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            out_data <= sum_next;
            out_last <= in_last;
        end
    end

    a_valid_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(out_valid));

endmodule

// File: add_tree.sv
`timescale 1ns/1ps
`include "dot_defines.svh"

module add_tree import dot_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    stream_if.sink   in,
    stream_if.source out
);
    // pair of partial sums between the two levels
    localparam int mid_w     = `DOT_PROD_W + 1;
    localparam int mid_count = `DOT_LANES / 2;

    logic [mid_count*mid_w-1:0] mid_data;
    logic                       mid_last;
    logic                       mid_valid;
    logic                       mid_ready;
    sum_t                       tree_sum;

    // four products into two partial sums
    tree_level #(
        .in_count(`DOT_LANES),
        .in_width(`DOT_PROD_W)
    ) level0_i (
        .clk      (clk),
        .rst      (rst),
        .in_data  (in.data),
        .in_last  (in.last),
        .in_valid (in.valid),
        .in_ready (in.ready),
        .out_data (mid_data),
        .out_last (mid_last),
        .out_valid(mid_valid),
        .out_ready(mid_ready)
    );

    // two partial sums into the exact total
    tree_level #(
        .in_count(mid_count),
        .in_width(mid_w)
    ) level1_i (
        .clk      (clk),
        .rst      (rst),
        .in_data  (mid_data),
        .in_last  (mid_last),
        .in_valid (mid_valid),
        .in_ready (mid_ready),
        .out_data (tree_sum),
        .out_last (out.last),
        .out_valid(out.valid),
        .out_ready(out.ready)
    );

    assign out.data = tree_sum;

endmodule

// File: skid_slice.sv
`timescale 1ns/1ps

module skid_slice import dot_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    stream_if.sink in,
    output sum_t   out_data,
    output logic   out_last,
    output logic   out_valid,
    input  logic   out_ready
);
    sum_t       data_mem [2];
    logic       last_mem [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       in_fire;
    logic       out_fire;

    // ready from occupancy only, so out_ready never reaches upstream
    assign in.ready  = count < 2'd2;
    assign out_valid = count != 2'd0;
    assign in_fire   = in.valid & in.ready;
    assign out_fire  = out_valid & out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (in_fire) begin
                wr_ptr <= ~wr_ptr;
            end
            if (out_fire) begin
                rd_ptr <= ~rd_ptr;
            end
            case ({in_fire, out_fire})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            data_mem[wr_ptr] <= in.data;
            last_mem[wr_ptr] <= in.last;
        end
    end

    // head entry is always on the output
    assign out_data = data_mem[rd_ptr];
    assign out_last = last_mem[rd_ptr];

    a_count_max: assert property (@(posedge clk) disable iff (rst)
        count <= 2'd2);

endmodule

// File: dot_top.sv
`timescale 1ns/1ps

module dot_top import dot_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    // A stream, carries the frame marker
    input  sample_vec_t a_data,
    input  logic        a_last,
    input  logic        a_valid,
    output logic        a_ready,

    // B stream
    input  sample_vec_t b_data,
    input  logic        b_valid,
    output logic        b_ready,

    // dot product result
    output sum_t        out_data,
    output logic        out_last,
    output logic        out_valid,
    input  logic        out_ready
);
    // lane products into the add tree
    stream_if #(.data_t(product_vec_t)) mul_if ();

    // tree sum into the output slice
    stream_if #(.data_t(sum_t)) sum_if ();

    lane_mul_stage mul_i (
        .clk    (clk),
        .rst    (rst),
        .a_data (a_data),
        .a_last (a_last),
        .a_valid(a_valid),
        .a_ready(a_ready),
        .b_data (b_data),
        .b_valid(b_valid),
        .b_ready(b_ready),
        .out    (mul_if)
    );

    add_tree tree_i (
        .clk(clk),
        .rst(rst),
        .in (mul_if),
        .out(sum_if)
    );

    // breaks the combinational ready chain at the output
    skid_slice slice_i (
        .clk      (clk),
        .rst      (rst),
        .in       (sum_if),
        .out_data (out_data),
        .out_last (out_last),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

endmodule

// File: tb_dot_top.sv
`timescale 1ns/1ps
`include "dot_defines.svh"

module tb_dot_top import dot_pkg::*; ();
    localparam int rand_count     = 1000;
    localparam int extreme_count  = 7;
    localparam int total_items    = 1 + 2 * rand_count + extreme_count;
    localparam int timeout_cycles = 8 * total_items + 200;

    logic        clk;
    logic        rst;
    sample_vec_t a_data;
    logic        a_last;
    logic        a_valid;
    logic        a_ready;
    sample_vec_t b_data;
    logic        b_valid;
    logic        b_ready;
    sum_t        out_data;
    logic        out_last;
    logic        out_valid;
    logic        out_ready;

    // per-test knobs, written between clock edges
    int          beat_total  = 0;
    int          a_pct       = 0;
    int          b_pct       = 0;
    int          ready_pct   = 0;
    bit          use_extremes = 1'b0;
    bit          force_last  = 1'b0;
    bit          stall_check = 1'b0;
    string       test_name   = "reset";
    int          a_sent      = 0;
    int          b_sent      = 0;

    // model queue and monitor state
    sum_t        exp_sum[$];
    logic        exp_last[$];
    sum_t        next_sum;
    logic        next_last;
    logic        a_fire_seen    = 1'b0;
    logic        b_fire_seen    = 1'b0;
    logic        out_fire_seen  = 1'b0;
    logic        held           = 1'b0;
    sum_t        held_data;
    logic        held_last;
    logic        prev_out_valid = 1'b0;
    int          cycles          = 0;
    int          join_count      = 0;
    int          out_count       = 0;
    int          last_join_cycle = 0;
    int          rise_cycle      = 0;
    int          base;

    dot_top dut_i (
        .clk      (clk),
        .rst      (rst),
        .a_data   (a_data),
        .a_last   (a_last),
        .a_valid  (a_valid),
        .a_ready  (a_ready),
        .b_data   (b_data),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .out_data (out_data),
        .out_last (out_last),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic stop_run();
        $display("sim failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        stop_run();
    endtask

    task automatic check_sum(input string name, input sum_t exp, input sum_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_last(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s last: expected %b, actual %b", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
            stop_run();
        end
    endtask

    // lane products in Q2.10, floor shift, then the exact sum
    function automatic sum_t dot_model(input sample_vec_t a, input sample_vec_t b);
        sample_t  sa;
        sample_t  sb;
        product_t p;
        int       total;
        total = 0;
        for (int i = 0; i < `DOT_LANES; i++) begin
            sa = a[i*`DOT_SAMPLE_W +: `DOT_SAMPLE_W];
            sb = b[i*`DOT_SAMPLE_W +: `DOT_SAMPLE_W];
            p = product_t'((int'(sa) * int'(sb)) >>> `DOT_PROD_SHIFT);
            total += int'(p);
        end
        return sum_t'(total);
    endfunction

    function automatic sample_vec_t extreme_vec();
        sample_vec_t v;
        sample_t     s;
        v = '0;
        for (int i = 0; i < `DOT_LANES; i++) begin
            case ($urandom % 3)
                0:       s = sample_t'(-128);
                1:       s = sample_t'(127);
                default: s = '0;
            endcase
            v[i*`DOT_SAMPLE_W +: `DOT_SAMPLE_W] = s;
        end
        return v;
    endfunction

    function automatic sample_vec_t new_vec();
        if (use_extremes) begin
            return extreme_vec();
        end
        return sample_vec_t'($urandom);
    endfunction

    // A, B and out_ready all come from this process
    initial begin
        void'($urandom(32'h7ec7));
        a_data    <= '0;
        a_last    <= 1'b0;
        a_valid   <= 1'b0;
        b_data    <= '0;
        b_valid   <= 1'b0;
        out_ready <= 1'b0;
        forever begin
            @(posedge clk);
            if (!rst) begin
                if (!a_valid || a_fire_seen) begin
                    if (a_sent < beat_total && int'($urandom % 100) < a_pct) begin
                        a_data  <= new_vec();
                        a_last  <= force_last ? 1'b1 : (($urandom % 8) == 0);
                        a_valid <= 1'b1;
                        a_sent++;
                    end else begin
                        a_valid <= 1'b0;
                    end
                end
                if (!b_valid || b_fire_seen) begin
                    if (b_sent < beat_total && int'($urandom % 100) < b_pct) begin
                        b_data  <= new_vec();
                        b_valid <= 1'b1;
                        b_sent++;
                    end else begin
                        b_valid <= 1'b0;
                    end
                end
            end
            out_ready <= int'($urandom % 100) < ready_pct;
        end
    end

    // sampled mid-cycle, these decide the transfers of the next rising edge
    always @(negedge clk) begin
        cycles++;
        if (cycles > timeout_cycles) begin
            abort_run($sformatf("timeout after %0d cycles, %0d of %0d results seen",
                cycles, out_count, beat_total));
        end
        a_fire_seen   = a_valid && a_ready;
        b_fire_seen   = b_valid && b_ready;
        out_fire_seen = out_valid && out_ready;

        if (a_ready && !b_valid) abort_run("a_ready high while b_valid is low");
        if (b_ready && !a_valid) abort_run("b_ready high while a_valid is low");
        if (a_fire_seen != b_fire_seen) abort_run("A and B did not transfer together");
        if (out_valid && join_count == 0) abort_run("out_valid high before any input");
        if (stall_check && (a_ready || b_ready)) begin
            abort_run("input ready while the pipeline should be full");
        end

        if (held) begin
            if (!out_valid) abort_run("out_valid dropped while out_ready was low");
            check_sum({test_name, " hold"}, held_data, out_data);
            check_last({test_name, " hold"}, held_last, out_last);
        end

        if (a_fire_seen) begin
            exp_sum.push_back(dot_model(a_data, b_data));
            exp_last.push_back(a_last);
            join_count++;
            last_join_cycle = cycles;
        end
        if (out_valid && !prev_out_valid) begin
            rise_cycle = cycles;
        end
        if (out_fire_seen) begin
            if (exp_sum.size() == 0) abort_run("output transfer with no expected result");
            next_sum  = exp_sum.pop_front();
            next_last = exp_last.pop_front();
            check_sum(test_name, next_sum, out_data);
            check_last(test_name, next_last, out_last);
            out_count++;
        end

        held           = out_valid && !out_ready;
        held_data      = out_data;
        held_last      = out_last;
        prev_out_valid = out_valid;
    end

    task automatic run_beats(input int n, input int pa, input int pb, input int pr,
                             input bit extremes, input bit all_last);
        @(negedge clk);
        a_pct        = pa;
        b_pct        = pb;
        ready_pct    = pr;
        use_extremes = extremes;
        force_last   = all_last;
        beat_total   = beat_total + n;
    endtask

    task automatic wait_outputs();
        while (out_count < beat_total) begin
            @(posedge clk);
        end
    endtask

    initial begin
        rst <= 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        repeat (6) @(posedge clk);

        test_name = "single";
        run_beats(1, 100, 100, 100, 1'b0, 1'b1);
        wait_outputs();
        check_count("single latency", 4, rise_cycle - last_join_cycle);

        test_name = "random";
        run_beats(rand_count, 70, 60, 100, 1'b0, 1'b0);
        wait_outputs();

        test_name = "backpressure";
        run_beats(rand_count, 70, 60, 50, 1'b0, 1'b0);
        wait_outputs();

        // fill the pipeline against a stalled output
        test_name = "capacity";
        base = join_count;
        run_beats(extreme_count, 100, 100, 0, 1'b1, 1'b0);
        while (join_count < base + 5) begin
            @(posedge clk);
        end
        stall_check = 1'b1;
        repeat (20) @(posedge clk);
        stall_check = 1'b0;
        check_count("capacity", 5, join_count - base);
        @(negedge clk);
        ready_pct = 100;
        wait_outputs();

        // room for a stray extra result to show up
        repeat (4) @(posedge clk);
        $display("sim passed");
        $finish;
    end

endmodule

// File: list.f
+incdir+.
dot_pkg.sv
stream_if.sv
lane_mul_stage.sv
tree_level.sv
add_tree.sv
skid_slice.sv
dot_top.sv
tb_dot_top.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_dot_top -f list.f -o tb_dot_top &&
./obj_dir/tb_dot_top || exit 1
